//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;		// data word, registers and ram
	typedef logic [9:0]  addr_t;		// ram word address
	typedef logic [3:0]  reg_idx_t;		// one of sixteen registers
	typedef logic [4:0]  flags_t;		// c l f z n, see FLAG_*

	// opcodes sit in instruction bits 15:12
	localparam logic [3:0] OP_ADD  = 4'h0;	// rd = rd + rs
	localparam logic [3:0] OP_SUB  = 4'h1;	// rd = rd - rs
	localparam logic [3:0] OP_AND  = 4'h2;
	localparam logic [3:0] OP_OR   = 4'h3;
	localparam logic [3:0] OP_XOR  = 4'h4;
	localparam logic [3:0] OP_MOV  = 4'h5;	// rd = rs
	localparam logic [3:0] OP_CMP  = 4'h6;	// flags only, rd untouched
	localparam logic [3:0] OP_ADDI = 4'h7;	// rd = rd + sext(imm8)
	localparam logic [3:0] OP_MOVI = 4'h8;	// rd = sext(imm8)
	localparam logic [3:0] OP_LOAD = 4'h9;	// rd = mem[rs]
	localparam logic [3:0] OP_STOR = 4'ha;	// mem[rs] = rd
	localparam logic [3:0] OP_JUMP = 4'hb;	// pc = rs[9:0]

	// bit positions inside flags_t
	localparam int FLAG_C = 0;		// carry out, borrow on sub/cmp
	localparam int FLAG_L = 1;		// unsigned rd < rs
	localparam int FLAG_F = 2;		// signed overflow
	localparam int FLAG_Z = 3;		// result zero
	localparam int FLAG_N = 4;		// result negative

	// multicycle sequencer, load is the only one visiting MEM_WB
	typedef enum logic [1:0] {
		FETCH,				// pc on the ram address
		CAPTURE,			// ram word into ir
		EXECUTE,			// alu, store, jump or load address
		MEM_WB				// load data into rd
	} state_t;

endpackage

`default_nettype wire

//--- design/cpu_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_fsm (
	input  wire        clk,
	input  wire        arst_n,
	input  wire  [3:0] opcode,		// from ir, valid in EXECUTE/MEM_WB
	output logic       pc_en,		// advance or load pc
	output logic       pc_jump,		// pc takes the jump target
	output logic       ir_en,		// capture ram word into ir
	output logic       reg_we,		// register file write
	output logic       flags_en,	// flags register load
	output logic       wb_mem,		// write ram data instead of alu result
	output logic       addr_sel,	// ram address from rs instead of pc
	output logic       write_en		// ram write strobe
);

	cpu_pkg::state_t state;
	cpu_pkg::state_t state_nx;
	logic            is_alu;		// register or immediate alu op
	logic            is_ld;
	logic            is_st;
	logic            is_jmp;

	assign is_alu = opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_MOV, cpu_pkg::OP_CMP,
		cpu_pkg::OP_ADDI, cpu_pkg::OP_MOVI};
	assign is_ld  = (opcode == cpu_pkg::OP_LOAD);
	assign is_st  = (opcode == cpu_pkg::OP_STOR);
	assign is_jmp = (opcode == cpu_pkg::OP_JUMP);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu_pkg::FETCH;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		case (state)
			cpu_pkg::FETCH:   state_nx = cpu_pkg::CAPTURE;
			cpu_pkg::CAPTURE: state_nx = cpu_pkg::EXECUTE;
			cpu_pkg::EXECUTE: state_nx = is_ld ? cpu_pkg::MEM_WB : cpu_pkg::FETCH;
			default:          state_nx = cpu_pkg::FETCH;	// MEM_WB ends the load
		endcase
	end

	// strobes are pure decode of state and opcode
	always_comb begin
		pc_en    = 1'b0;
		pc_jump  = 1'b0;
		ir_en    = 1'b0;
		reg_we   = 1'b0;
		flags_en = 1'b0;
		wb_mem   = 1'b0;
		addr_sel = 1'b0;
		write_en = 1'b0;
		case (state)
			cpu_pkg::CAPTURE: ir_en = 1'b1;		// ram word is on data_out now
			cpu_pkg::EXECUTE: begin
				pc_en    = !is_ld;		// load advances in MEM_WB instead
				pc_jump  = is_jmp;
				reg_we   = is_alu && (opcode != cpu_pkg::OP_CMP);
				flags_en = is_alu;
				addr_sel = is_ld || is_st;	// rs points into ram
				write_en = is_st;
			end
			cpu_pkg::MEM_WB: begin
				pc_en  = 1'b1;
				reg_we = 1'b1;
				wb_mem = 1'b1;			// read data arrived one cycle after addr
			end
			default: ;				// FETCH only drives pc onto addr
		endcase
	end

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    ir_en,		// load strobe from fsm
	input  wire  cpu_pkg::word_t   data_out,	// ram read data
	output logic [3:0]             opcode,
	output cpu_pkg::reg_idx_t      rd,
	output cpu_pkg::reg_idx_t      rs,
	output cpu_pkg::word_t         imm		// sign extended imm8
);

	cpu_pkg::word_t ir;				// instruction register

	// reset value decodes as mov r0,r0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ir <= {cpu_pkg::OP_MOV, 12'h000};
		end else if (ir_en) begin
			ir <= data_out;
		end
	end

	// field split
	assign opcode = ir[15:12];
	assign rd     = ir[11:8];
	assign rs     = ir[7:4];			// overlaps imm8 high nibble
	assign imm    = {{8{ir[7]}}, ir[7:0]};	// sign extend to a word

endmodule

`default_nettype wire

//--- design/program_counter.sv
`timescale 1ns/1ns
`default_nettype none

module program_counter (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire                   pc_en,		// step or jump this cycle
	input  wire                   pc_jump,		// take target instead of pc + 1
	input  wire  cpu_pkg::addr_t  target,		// low bits of rs
	output cpu_pkg::addr_t        pc
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;				// execution starts at word 0
		end else if (pc_en) begin
			if (pc_jump) begin
				pc <= target;
			end else begin
				pc <= pc + 10'd1;		// wraps at the top of ram
			end
		end
	end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire                      we,		// write port strobe
	input  wire  cpu_pkg::reg_idx_t  wr_idx,
	input  wire  cpu_pkg::reg_idx_t  rd_idx,
	input  wire  cpu_pkg::reg_idx_t  rs_idx,
	input  wire  cpu_pkg::word_t     wr_data,
	output cpu_pkg::word_t           rd_data,
	output cpu_pkg::word_t           rs_data,
	output cpu_pkg::word_t           r1		// display register
);

	cpu_pkg::word_t regs [16];

	// every register clears, r0 is an ordinary register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// asynchronous reads
	assign rd_data = regs[rd_idx];
	assign rs_data = regs[rs_idx];
	assign r1      = regs[1];		// new value visible the cycle after the write

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire  [3:0]            opcode,
	input  wire  cpu_pkg::word_t  rd_data,		// a operand
	input  wire  cpu_pkg::word_t  rs_data,
	input  wire  cpu_pkg::word_t  imm,
	input  wire                   flags_en,
	output cpu_pkg::word_t        result,
	output cpu_pkg::flags_t       flags
);

	cpu_pkg::word_t  b;				// b operand after imm select
	cpu_pkg::flags_t flags_nx;
	logic [16:0]     sum;			// bit 16 is carry or borrow
	logic            is_sub;		// sub and cmp share the subtractor
	logic            is_arith;		// ops that produce c and f
	logic            ovf;

	assign b = (opcode == cpu_pkg::OP_ADDI || opcode == cpu_pkg::OP_MOVI) ? imm : rs_data;

	assign is_sub   = (opcode == cpu_pkg::OP_SUB) || (opcode == cpu_pkg::OP_CMP);
	assign is_arith = is_sub || (opcode == cpu_pkg::OP_ADD) || (opcode == cpu_pkg::OP_ADDI);

	assign sum = is_sub ? ({1'b0, rd_data} - {1'b0, b}) : ({1'b0, rd_data} + {1'b0, b});

	// signed overflow: operand signs vs result sign
	assign ovf = is_sub ? ((rd_data[15] != b[15]) && (sum[15] != rd_data[15]))
			    : ((rd_data[15] == b[15]) && (sum[15] != rd_data[15]));

	always_comb begin
		case (opcode)
			cpu_pkg::OP_ADD,
			cpu_pkg::OP_SUB,
			cpu_pkg::OP_CMP,
			cpu_pkg::OP_ADDI: result = sum[15:0];
			cpu_pkg::OP_AND:  result = rd_data & b;
			cpu_pkg::OP_OR:   result = rd_data | b;
			cpu_pkg::OP_XOR:  result = rd_data ^ b;
			cpu_pkg::OP_MOV,
			cpu_pkg::OP_MOVI: result = b;
			default:          result = rd_data;	// non alu ops never write back
		endcase
	end

	// logic and moves leave c, f, l cleared
	always_comb begin
		flags_nx                 = '0;
		flags_nx[cpu_pkg::FLAG_C] = is_arith && sum[16];
		flags_nx[cpu_pkg::FLAG_F] = is_arith && ovf;
		flags_nx[cpu_pkg::FLAG_L] = is_sub && (rd_data < b);	// unsigned compare
		flags_nx[cpu_pkg::FLAG_Z] = (result == '0);
		flags_nx[cpu_pkg::FLAG_N] = result[15];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (flags_en) begin
			flags <= flags_nx;			// only alu ops in EXECUTE
		end
	end

endmodule

`default_nettype wire

//--- design/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
	input  wire                   clk,
	input  wire                   arst_n,
	output cpu_pkg::flags_t       flag_leds,	// flags register
	output cpu_pkg::word_t        r1,		// display register
	output logic                  write_en,		// ram write strobe
	output cpu_pkg::addr_t        addr,		// ram word address
	output cpu_pkg::word_t        data_in,		// ram write data
	input  wire  cpu_pkg::word_t  data_out		// ram read data, one cycle late
);

	logic              pc_en;
	logic              pc_jump;
	logic              ir_en;
	logic              reg_we;
	logic              flags_en;
	logic              wb_mem;
	logic              addr_sel;
	logic [3:0]        opcode;
	cpu_pkg::reg_idx_t rd;
	cpu_pkg::reg_idx_t rs;
	cpu_pkg::word_t    imm;
	cpu_pkg::word_t    rd_data;
	cpu_pkg::word_t    rs_data;
	cpu_pkg::word_t    result;
	cpu_pkg::word_t    wr_data;		// register write mux out
	cpu_pkg::addr_t    pc;

	cpu_fsm u_cpu_fsm (
		.clk      (clk),
		.arst_n   (arst_n),
		.opcode   (opcode),
		.pc_en    (pc_en),
		.pc_jump  (pc_jump),
		.ir_en    (ir_en),
		.reg_we   (reg_we),
		.flags_en (flags_en),
		.wb_mem   (wb_mem),
		.addr_sel (addr_sel),
		.write_en (write_en)		// straight out to the ram
	);

	instr_decoder u_instr_decoder (
		.clk      (clk),
		.arst_n   (arst_n),
		.ir_en    (ir_en),
		.data_out (data_out),
		.opcode   (opcode),
		.rd       (rd),
		.rs       (rs),
		.imm      (imm)
	);

	program_counter u_program_counter (
		.clk     (clk),
		.arst_n  (arst_n),
		.pc_en   (pc_en),
		.pc_jump (pc_jump),
		.target  (rs_data[9:0]),	// register indirect jump
		.pc      (pc)
	);

	// load data or alu result into rd
	assign wr_data = wb_mem ? data_out : result;

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.we      (reg_we),
		.wr_idx  (rd),
		.rd_idx  (rd),
		.rs_idx  (rs),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.rs_data (rs_data),
		.r1      (r1)
	);

	alu u_alu (
		.clk      (clk),
		.arst_n   (arst_n),
		.opcode   (opcode),
		.rd_data  (rd_data),
		.rs_data  (rs_data),
		.imm      (imm),
		.flags_en (flags_en),
		.result   (result),
		.flags    (flag_leds)
	);

	// pc for fetch, rs for load/store
	assign addr    = addr_sel ? rs_data[9:0] : pc;
	assign data_in = rd_data;			// store writes rd

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	logic                  clk = 1'b0;
	logic                  arst_n;
	cpu_pkg::flags_t       flag_leds;
	cpu_pkg::word_t        r1;
	logic                  write_en;
	cpu_pkg::addr_t        addr;
	cpu_pkg::word_t        data_in;
	cpu_pkg::word_t        data_out;

	logic [15:0] mem [1024];		// ram seen by the dut
	logic [15:0] model_mem [1024];	// reference copy
	int          tag [1024];		// test number of each program word
	logic [9:0]  rd_addr;			// ram read address register
	logic [3:0]  alu_ops [8] = '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_MOV, cpu_pkg::OP_CMP, cpu_pkg::OP_CMP};

	// expected state after each executed instruction
	logic [9:0]  step_pc [128];
	int          step_len [128];
	logic [15:0] step_r1 [128];
	logic [4:0]  step_flags [128];
	logic        step_st [128];
	logic [9:0]  step_st_addr [128];
	logic [15:0] step_st_data [128];
	int          step_tag [128];

	int          prog_len;
	int          n_steps;
	int          total_cycles;
	int          cycles = 0;
	int          limit = 1000;		// replaced once the program is known
	int          cur_test;
	int          test_errs [6];
	string       test_name [6];
	int          n_pass = 0;
	int          n_fail = 0;

	cpu_core u_cpu_core (
		.clk       (clk),
		.arst_n    (arst_n),
		.flag_leds (flag_leds),
		.r1        (r1),
		.write_en  (write_en),
		.addr      (addr),
		.data_in   (data_in),
		.data_out  (data_out)
	);

	always #4 clk = ~clk;			// 8 ns period

	// synchronous ram, read word handed over on the falling edge
	always @(posedge clk) begin
		if (write_en) begin
			mem[addr] = data_in;
		end
		rd_addr = addr;
	end

	always @(negedge clk) begin
		data_out = mem[rd_addr];
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout: program did not complete within %0d cycles", limit);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $urandom();
		return r[7:0];
	endfunction

	function automatic logic [15:0] rand_word();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	function automatic logic [15:0] encode(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] lo);
		return {op, rd, lo};			// lo is imm8 or {rs, 0}
	endfunction

	task automatic emit(input logic [15:0] w, input int t);
		mem[prog_len] = w;
		tag[prog_len] = t;
		prog_len++;
	endtask

	task automatic fill_memory();
		logic [9:0] a;
		for (int i = 0; i < 1024; i++) begin
			a = 10'(i);
			mem[i] = {a, a[5:0]} ^ 16'hc3a5;	// unique per word
			tag[i] = 0;
		end
	endtask

	task automatic build_program();
		logic [7:0] a_imm;
		logic [7:0] b_imm;
		logic [7:0] tgt;
		prog_len = 0;
		for (int i = 0; i < 4; i++) begin
			emit(encode(cpu_pkg::OP_MOVI, 4'd1, rand_byte()), 2);
			emit(encode(cpu_pkg::OP_ADDI, 4'd1, rand_byte()), 2);
		end
		for (int j = 0; j < 16; j++) begin
			mem[896 + j] = rand_word();	// operands at 0x380, reached by imm 0x80
		end
		for (int j = 0; j < 8; j++) begin
			a_imm = 8'h80 + 8'(2 * j);
			b_imm = (j == 7) ? a_imm : a_imm + 8'd1;	// last cmp on equal values
			emit(encode(cpu_pkg::OP_MOVI, 4'd2, a_imm), 3);
			emit(encode(cpu_pkg::OP_LOAD, 4'd1, 8'h20), 3);	// r1 = mem[r2]
			emit(encode(cpu_pkg::OP_MOVI, 4'd2, b_imm), 3);
			emit(encode(cpu_pkg::OP_LOAD, 4'd3, 8'h20), 3);	// r3 = mem[r2]
			emit(encode(alu_ops[j], 4'd1, 8'h30), 3);		// r1 op r3
		end
		for (int i = 0; i < 3; i++) begin
			tgt = rand_byte() | 8'hc0;		// 0x3c0..0x3ff
			emit(encode(cpu_pkg::OP_ADDI, 4'd1, rand_byte()), 4);
			emit(encode(cpu_pkg::OP_MOVI, 4'd4, tgt), 4);
			emit(encode(cpu_pkg::OP_STOR, 4'd1, 8'h40), 4);	// mem[r4] = r1
			emit(encode(cpu_pkg::OP_MOVI, 4'd1, rand_byte()), 4);	// clobber r1
			emit(encode(cpu_pkg::OP_LOAD, 4'd1, 8'h40), 4);
		end
		for (int i = 0; i < 2; i++) begin
			tgt = 8'(prog_len + 4);
			emit(encode(cpu_pkg::OP_MOVI, 4'd5, tgt), 5);
			emit(encode(cpu_pkg::OP_JUMP, 4'd0, 8'h50), 5);
			emit(encode(cpu_pkg::OP_MOVI, 4'd1, rand_byte()), 5);	// skipped
			emit(encode(cpu_pkg::OP_ADDI, 4'd1, 8'h01), 5);		// skipped
			emit(encode(cpu_pkg::OP_ADDI, 4'd1, rand_byte()), 5);
		end
	endtask

	// instruction level reference, one pass over the executed path
	task automatic run_model();
		logic [15:0] regs [16];
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [4:0]  fl;
		logic [9:0]  pc;
		logic [3:0]  op;
		int          sa;
		int          sb;
		int          ssum;
		int          usum;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		fl = '0;
		pc = '0;
		n_steps = 0;
		total_cycles = 0;
		while (int'(pc) != prog_len && n_steps < 128) begin
			w  = model_mem[pc];
			op = w[15:12];
			a  = regs[w[11:8]];
			b  = (op == cpu_pkg::OP_ADDI || op == cpu_pkg::OP_MOVI) ?
				{{8{w[7]}}, w[7:0]} : regs[w[7:4]];
			sa = int'($signed(a));
			sb = int'($signed(b));
			step_pc[n_steps]  = pc;
			step_tag[n_steps] = tag[pc];
			step_len[n_steps] = 3;
			step_st[n_steps]  = 1'b0;
			pc = pc + 10'd1;
			case (op)
				cpu_pkg::OP_LOAD: begin
					regs[w[11:8]] = model_mem[b[9:0]];
					step_len[n_steps] = 4;
				end
				cpu_pkg::OP_STOR: begin
					model_mem[b[9:0]] = a;
					step_st[n_steps] = 1'b1;
					step_st_addr[n_steps] = b[9:0];
					step_st_data[n_steps] = a;
				end
				cpu_pkg::OP_JUMP: pc = b[9:0];
				default: begin
					fl = '0;
					case (op)
						cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI: begin
							usum = int'(a) + int'(b);
							ssum = sa + sb;
							res = usum[15:0];
							fl[cpu_pkg::FLAG_C] = (usum > 65535);
							fl[cpu_pkg::FLAG_F] = (ssum > 32767 || ssum < -32768);
						end
						cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: begin
							ssum = sa - sb;
							res = a - b;
							fl[cpu_pkg::FLAG_C] = (a < b);	// borrow
							fl[cpu_pkg::FLAG_L] = (a < b);
							fl[cpu_pkg::FLAG_F] = (ssum > 32767 || ssum < -32768);
						end
						cpu_pkg::OP_AND: res = a & b;
						cpu_pkg::OP_OR:  res = a | b;
						cpu_pkg::OP_XOR: res = a ^ b;
						default:         res = b;		// mov, movi
					endcase
					fl[cpu_pkg::FLAG_Z] = (res == 16'h0000);
					fl[cpu_pkg::FLAG_N] = res[15];
					if (op != cpu_pkg::OP_CMP) begin
						regs[w[11:8]] = res;
					end
				end
			endcase
			step_r1[n_steps] = regs[1];
			step_flags[n_steps] = fl;
			total_cycles += step_len[n_steps];
			n_steps++;
		end
	endtask

	task automatic check_word(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			test_errs[cur_test]++;
		end
	endtask

	task automatic check_reset_state();
		check_word("write_en after reset", 16'(write_en), 16'h0000);
		check_word("addr after reset", 16'(addr), 16'h0000);
		check_word("r1 after reset", r1, 16'h0000);
		check_word("flags after reset", 16'(flag_leds), 16'h0000);
	endtask

	task automatic report_test(input int t);
		if (test_errs[t] == 0) begin
			$display("test %0d %s: ok", t, test_name[t]);
			n_pass++;
		end else begin
			$display("test %0d %s: %0d errors", t, test_name[t], test_errs[t]);
			n_fail++;
		end
	endtask

	initial begin
		void'($urandom(32'h0002a4d9));
		arst_n = 1'b0;
		data_out = '0;
		test_name = '{"", "reset state", "movi and addi", "register alu ops",
			"store and load", "register jump"};
		test_errs = '{0, 0, 0, 0, 0, 0};
		fill_memory();
		build_program();
		model_mem = mem;
		run_model();
		limit = 2 * total_cycles + 50;
		cur_test = 1;
		repeat (4) begin
			@(negedge clk);
			check_reset_state();
		end
		arst_n = 1'b1;				// released in step 0 fetch
		for (int k = 0; k < n_steps; k++) begin
			cur_test = (k == 0) ? 1 : step_tag[k];
			check_word("write_en in fetch", 16'(write_en), 16'h0000);
			check_word("fetch addr", 16'(addr), 16'(step_pc[k]));	// jump target too
			@(negedge clk);			// capture
			if (k == 0) begin
				check_reset_state();
			end
			@(negedge clk);			// execute
			if (k == 0) begin
				check_reset_state();
				report_test(1);		// first write lands on this edge
			end
			cur_test = step_tag[k];
			if (step_st[k]) begin
				check_word("store write_en", 16'(write_en), 16'h0001);
				check_word("store addr", 16'(addr), 16'(step_st_addr[k]));
				check_word("store data_in", data_in, step_st_data[k]);
			end else begin
				check_word("write_en outside store", 16'(write_en), 16'h0000);
			end
			if (step_len[k] == 4) begin
				@(negedge clk);		// load writeback
			end
			@(negedge clk);			// next fetch
			check_word("r1", r1, step_r1[k]);
			check_word("flags", 16'(flag_leds), 16'(step_flags[k]));
			if (step_st[k]) begin
				check_word("ram word", mem[step_st_addr[k]], step_st_data[k]);
			end
			if (k == n_steps - 1 || step_tag[k + 1] != step_tag[k]) begin
				report_test(step_tag[k]);
			end
		end
		$display("tests run: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
design/cpu_pkg.sv
design/cpu_fsm.sv
design/instr_decoder.sv
design/program_counter.sv
design/reg_file.sv
design/alu.sv
design/cpu_core.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# compile the cpu testbench with verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module cpu_tb -f list.f -o cpu_tb
./obj_dir/cpu_tb > sim.log
cat sim.log

if grep -q "Verification passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
